/* common/clock_pkg.sv */
package clock_pkg;

    ////////////////////////////////////////////////////////////
    // display geometry
    ////////////////////////////////////////////////////////////
    localparam int NUM_DIGITS = 8;
    localparam int DIGIT_W    = 4;
    localparam int FIELD_W    = 7;   // holds 0..99

    ////////////////////////////////////////////////////////////
    // counting limits
    ////////////////////////////////////////////////////////////
    localparam int CENTI_PER_SEC = 100;
    localparam int SEC_PER_MIN   = 60;
    localparam int MIN_PER_HOUR  = 60;
    localparam int HOURS_PER_DAY = 24;
    localparam int HALF_DAY      = 12;  // 12-hour wrap point

    localparam logic [DIGIT_W-1:0] BCD_MAX     = 4'd9;
    localparam logic [DIGIT_W-1:0] BLANK_DIGIT = 4'hf;  // decodes to all dark

    // field select codes
    localparam logic [1:0] PARA_NONE = 2'd0;
    localparam logic [1:0] PARA_SEC  = 2'd1;
    localparam logic [1:0] PARA_MIN  = 2'd2;
    localparam logic [1:0] PARA_HOUR = 2'd3;

    ////////////////////////////////////////////////////////////
    // segment constants, active low
    ////////////////////////////////////////////////////////////
    localparam logic [7:0] SEG_DARK = 8'hff;
    // points after hours, minutes and seconds ones digits
    localparam logic [NUM_DIGITS-1:0] POINT_POSITIONS = 8'b0101_0100;

endpackage

/* common/frame_if.sv */
`timescale 1ns/1ps

// one display frame passed with a four-phase req/ack handshake
interface frame_if import clock_pkg::*; ();

    logic                               req;
    logic                               ack;
    logic [NUM_DIGITS-1:0][DIGIT_W-1:0] digits;  // position 7 is leftmost
    logic [NUM_DIGITS-1:0]              blink;

    modport source (
        output req,
        output digits,
        output blink,
        input  ack
    );

    modport sink (
        input  req,
        input  digits,
        input  blink,
        output ack
    );

endinterface

/* src/timekeeping/digit_formatter.sv */
`timescale 1ns/1ps

module digit_formatter import clock_pkg::*; (
    input  logic [FIELD_W-1:0]                hours,
    input  logic [FIELD_W-1:0]                minutes,
    input  logic [FIELD_W-1:0]                seconds,
    input  logic [FIELD_W-1:0]                centis,
    input  logic                              time_format,
    input  logic                              setting,
    input  logic [1:0]                        para_select,
    output logic [NUM_DIGITS-1:0][DIGIT_W-1:0] digits,
    output logic [NUM_DIGITS-1:0]             blink
);
    logic [FIELD_W-1:0] hours_disp;

    // tens digit in the upper nibble
    function automatic logic [2*DIGIT_W-1:0] split(input logic [FIELD_W-1:0] value);
        return {DIGIT_W'(value / FIELD_W'(10)), DIGIT_W'(value % FIELD_W'(10))};
    endfunction

    assign hours_disp = (time_format && hours > FIELD_W'(HALF_DAY)) ?
                        hours - FIELD_W'(HALF_DAY) : hours;

    assign digits = {split(hours_disp), split(minutes), split(seconds), split(centis)};

    always_comb begin
        blink = '0;
        if (setting) begin
            case (para_select)
                PARA_SEC:  blink[3:2] = 2'b11;
                PARA_MIN:  blink[5:4] = 2'b11;
                PARA_HOUR: blink[7:6] = 2'b11;
                default:   ;
            endcase
        end
    end

endmodule

/* src/timekeeping/time_keeper.sv */
`timescale 1ns/1ps

module time_keeper import clock_pkg::*; #(
    parameter int CENTI_DIV = 1_000_000
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               time_format,
    input  logic [1:0]         para_select,
    input  logic               read_para,
    input  logic [DIGIT_W-1:0] data_h,
    input  logic [DIGIT_W-1:0] data_l,
    output logic               afternoon,
    frame_if.source            frame
);
    localparam int DIV_W = (CENTI_DIV > 1) ? $clog2(CENTI_DIV) : 1;

    logic [FIELD_W-1:0] hours;
    logic [FIELD_W-1:0] minutes;
    logic [FIELD_W-1:0] seconds;
    logic [FIELD_W-1:0] centis;
    logic [FIELD_W-1:0] hours_nxt;
    logic [FIELD_W-1:0] minutes_nxt;
    logic [FIELD_W-1:0] seconds_nxt;
    logic [FIELD_W-1:0] centis_nxt;
    logic [DIV_W-1:0]   div_cnt;
    logic               committed;
    logic               setting;
    logic               tick;
    logic [DIGIT_W-1:0] bcd_h;
    logic [DIGIT_W-1:0] bcd_l;
    logic [FIELD_W-1:0] set_raw;

    logic [NUM_DIGITS-1:0][DIGIT_W-1:0] fmt_digits;
    logic [NUM_DIGITS-1:0][DIGIT_W-1:0] frame_digits;
    logic [NUM_DIGITS-1:0]              fmt_blink;
    logic [NUM_DIGITS-1:0]              frame_blink;
    logic                               req_q;
    logic                               loaded;   // a frame has gone out since reset
    logic                               pending;
    logic                               launch;

    assign setting = (para_select != PARA_NONE) && !committed;
    assign tick    = !setting && (div_cnt == DIV_W'(CENTI_DIV - 1));

    // clamp each digit, then combine
    assign bcd_h   = (data_h > BCD_MAX) ? BCD_MAX : data_h;
    assign bcd_l   = (data_l > BCD_MAX) ? BCD_MAX : data_l;
    assign set_raw = FIELD_W'(bcd_h) * FIELD_W'(10) + FIELD_W'(bcd_l);

    ////////////////////////////////////////////////////////////
    // next time value
    ////////////////////////////////////////////////////////////
    always_comb begin
        hours_nxt   = hours;
        minutes_nxt = minutes;
        seconds_nxt = seconds;
        centis_nxt  = centis;
        if (setting) begin
            case (para_select)
                PARA_SEC:  seconds_nxt = set_raw % FIELD_W'(SEC_PER_MIN);
                PARA_MIN:  minutes_nxt = set_raw % FIELD_W'(MIN_PER_HOUR);
                PARA_HOUR: hours_nxt   = set_raw % FIELD_W'(HOURS_PER_DAY);
                default:   ;
            endcase
        end else if (tick) begin
            if (centis == FIELD_W'(CENTI_PER_SEC - 1)) begin
                centis_nxt = '0;
                if (seconds == FIELD_W'(SEC_PER_MIN - 1)) begin
                    seconds_nxt = '0;
                    if (minutes == FIELD_W'(MIN_PER_HOUR - 1)) begin
                        minutes_nxt = '0;
                        if (hours == FIELD_W'(HOURS_PER_DAY - 1)) begin
                            hours_nxt = '0;
                        end else begin
                            hours_nxt = hours + 1'b1;
                        end
                    end else begin
                        minutes_nxt = minutes + 1'b1;
                    end
                end else begin
                    seconds_nxt = seconds + 1'b1;
                end
            end else begin
                centis_nxt = centis + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            hours     <= '0;
            minutes   <= '0;
            seconds   <= '0;
            centis    <= '0;
            div_cnt   <= '0;
            committed <= 1'b0;
            afternoon <= 1'b0;
        end else begin
            hours     <= hours_nxt;
            minutes   <= minutes_nxt;
            seconds   <= seconds_nxt;
            centis    <= centis_nxt;
            afternoon <= time_format && (hours_nxt > FIELD_W'(HALF_DAY));
            if (setting && read_para) begin
                committed <= 1'b1;
            end else if (para_select == PARA_NONE) begin
                committed <= 1'b0;                  // re-arm
            end
            if (setting) begin
                if (read_para) begin
                    div_cnt <= '0;                  // restart on commit
                end
            end else if (tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    digit_formatter i_digit_formatter (
        .hours       (hours),
        .minutes     (minutes),
        .seconds     (seconds),
        .centis      (centis),
        .time_format (time_format),
        .setting     (setting),
        .para_select (para_select),
        .digits      (fmt_digits),
        .blink       (fmt_blink)
    );

    ////////////////////////////////////////////////////////////
    // frame launch
    ////////////////////////////////////////////////////////////
    assign pending = !loaded || (fmt_digits != frame_digits) || (fmt_blink != frame_blink);
    assign launch  = !req_q && !frame.ack && pending;

    always_ff @(posedge clk) begin
        if (!reset) begin
            req_q  <= 1'b0;
            loaded <= 1'b0;
        end else if (launch) begin
            req_q  <= 1'b1;
            loaded <= 1'b1;
        end else if (req_q && frame.ack) begin
            req_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            frame_digits <= fmt_digits;  // newest frame at req rise
            frame_blink  <= fmt_blink;
        end
    end

    assign frame.req    = req_q;
    assign frame.digits = frame_digits;
    assign frame.blink  = frame_blink;

endmodule

/* src/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer import clock_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    frame_if.sink    upstream,
    frame_if.source  downstream
);
    logic                               full;
    logic                               up_ack;
    logic                               down_req;
    logic                               take;
    logic [NUM_DIGITS-1:0][DIGIT_W-1:0] store_digits;
    logic [NUM_DIGITS-1:0]              store_blink;

    // only an empty buffer answers, so back-pressure reaches the time keeper
    assign take = upstream.req && !up_ack && !full;

    always_ff @(posedge clk) begin
        if (!reset) begin
            full     <= 1'b0;
            up_ack   <= 1'b0;
            down_req <= 1'b0;
        end else begin
            if (up_ack && !upstream.req) begin
                up_ack <= 1'b0;
            end
            if (down_req && downstream.ack) begin
                down_req <= 1'b0;
            end
            // empty once the scanner has dropped ack as well
            if (full && !down_req && !downstream.ack) begin
                full <= 1'b0;
            end
            if (take) begin
                up_ack   <= 1'b1;
                full     <= 1'b1;
                down_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            store_digits <= upstream.digits;
            store_blink  <= upstream.blink;
        end
    end

    assign upstream.ack      = up_ack;
    assign downstream.req    = down_req;
    assign downstream.digits = store_digits;
    assign downstream.blink  = store_blink;

endmodule

/* src/display/seg_scanner.sv */
`timescale 1ns/1ps

module seg_scanner import clock_pkg::*; #(
    parameter int SCAN_DIV  = 10_000,
    parameter int BLINK_DIV = 50_000_000
) (
    input  logic                  clk,
    input  logic                  reset,
    frame_if.sink                 frame,
    output logic [7:0]            segs,
    output logic [NUM_DIGITS-1:0] an
);
    localparam int SCAN_W  = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam int BLINK_W = (BLINK_DIV > 1) ? $clog2(BLINK_DIV) : 1;
    localparam int POS_W   = $clog2(NUM_DIGITS);

    logic                               shown;  // first frame captured
    logic                               ack_q;
    logic [POS_W-1:0]                   pos;
    logic [SCAN_W-1:0]                  scan_cnt;
    logic [BLINK_W-1:0]                 blink_cnt;
    logic                               blink_phase;  // high in second half
    logic                               step;
    logic                               wrap;
    logic                               take;
    logic [DIGIT_W-1:0]                 cur_code;
    logic [NUM_DIGITS-1:0][DIGIT_W-1:0] show_digits;
    logic [NUM_DIGITS-1:0]              show_blink;

    // gfedcba, active low
    function automatic logic [6:0] seg_decode(input logic [DIGIT_W-1:0] code);
        case (code)
            4'd0:    return 7'b100_0000;
            4'd1:    return 7'b111_1001;
            4'd2:    return 7'b010_0100;
            4'd3:    return 7'b011_0000;
            4'd4:    return 7'b001_1001;
            4'd5:    return 7'b001_0010;
            4'd6:    return 7'b000_0010;
            4'd7:    return 7'b111_1000;
            4'd8:    return 7'b000_0000;
            4'd9:    return 7'b001_0000;
            default: return SEG_DARK[6:0];  // includes BLANK_DIGIT
        endcase
    endfunction

    assign step = shown && (scan_cnt == SCAN_W'(SCAN_DIV - 1));
    assign wrap = step && (pos == '0);
    // new frames only between full scans
    assign take = frame.req && !ack_q && (!shown || wrap);

    always_ff @(posedge clk) begin
        if (!reset) begin
            shown       <= 1'b0;
            ack_q       <= 1'b0;
            pos         <= POS_W'(NUM_DIGITS - 1);
            scan_cnt    <= '0;
            blink_cnt   <= '0;
            blink_phase <= 1'b0;
        end else begin
            if (take) begin
                shown <= 1'b1;
                ack_q <= 1'b1;
            end else if (ack_q && !frame.req) begin
                ack_q <= 1'b0;
            end
            if (step) begin
                scan_cnt <= '0;
                pos      <= pos - 1'b1;      // 0 wraps to 7
            end else if (shown) begin
                scan_cnt <= scan_cnt + 1'b1;
            end
            if (blink_cnt == BLINK_W'(BLINK_DIV - 1)) begin
                blink_cnt   <= '0;
                blink_phase <= !blink_phase;
            end else begin
                blink_cnt <= blink_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            show_digits <= frame.digits;
            show_blink  <= frame.blink;
        end
    end

    assign frame.ack = ack_q;

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////
    assign cur_code = (show_blink[pos] && blink_phase) ? BLANK_DIGIT : show_digits[pos];
    assign an       = shown ? ~(NUM_DIGITS'(1) << pos) : '1;
    assign segs     = shown ? {~POINT_POSITIONS[pos], seg_decode(cur_code)} : SEG_DARK;

endmodule

/* src/clock_top.sv */
`timescale 1ns/1ps

module clock_top import clock_pkg::*; #(
    parameter int CENTI_DIV = 1_000_000,
    parameter int SCAN_DIV  = 10_000,
    parameter int BLINK_DIV = 50_000_000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  time_format,  // 1 = 12-hour
    input  logic [1:0]            para_select,
    input  logic                  read_para,
    input  logic [DIGIT_W-1:0]    data_h,
    input  logic [DIGIT_W-1:0]    data_l,
    output logic                  afternoon,
    output logic [7:0]            segs,
    output logic [NUM_DIGITS-1:0] an
);
    frame_if frame_in ();
    frame_if frame_out ();

    time_keeper #(
        .CENTI_DIV (CENTI_DIV)
    ) i_time_keeper (
        .clk         (clk),
        .reset       (reset),
        .time_format (time_format),
        .para_select (para_select),
        .read_para   (read_para),
        .data_h      (data_h),
        .data_l      (data_l),
        .afternoon   (afternoon),
        .frame       (frame_in.source)
    );

    frame_buffer i_frame_buffer (
        .clk        (clk),
        .reset      (reset),
        .upstream   (frame_in.sink),
        .downstream (frame_out.source)
    );

    seg_scanner #(
        .SCAN_DIV  (SCAN_DIV),
        .BLINK_DIV (BLINK_DIV)
    ) i_seg_scanner (
        .clk   (clk),
        .reset (reset),
        .frame (frame_out.sink),
        .segs  (segs),
        .an    (an)
    );

endmodule

/* bench/clock_props.sv */
`timescale 1ns/1ps

module clock_props import clock_pkg::*; (
    input logic                               clk,
    input logic                               reset,
    input logic                               up_req,
    input logic                               up_ack,
    input logic [NUM_DIGITS-1:0][DIGIT_W-1:0] up_digits,
    input logic [NUM_DIGITS-1:0]              up_blink,
    input logic                               down_req,
    input logic                               down_ack,
    input logic [NUM_DIGITS-1:0][DIGIT_W-1:0] down_digits,
    input logic [NUM_DIGITS-1:0]              down_blink
);

    ////////////////////////////////////////////////////////////
    // frame_in, time keeper to buffer
    ////////////////////////////////////////////////////////////
    up_req_held: assert property (@(posedge clk) disable iff (!reset)
        up_req && !up_ack |=> up_req)
        else $error("frame_in req dropped before ack");

    up_data_stable: assert property (@(posedge clk) disable iff (!reset)
        up_req |=> (!up_req || ($stable(up_digits) && $stable(up_blink))))
        else $error("frame_in data changed while req was high");

    up_ack_after_req: assert property (@(posedge clk) disable iff (!reset)
        $rose(up_ack) |-> up_req)
        else $error("frame_in ack rose without req");

    ////////////////////////////////////////////////////////////
    // frame_out, buffer to scanner
    ////////////////////////////////////////////////////////////
    down_req_held: assert property (@(posedge clk) disable iff (!reset)
        down_req && !down_ack |=> down_req)
        else $error("frame_out req dropped before ack");

    down_data_stable: assert property (@(posedge clk) disable iff (!reset)
        down_req |=> (!down_req || ($stable(down_digits) && $stable(down_blink))))
        else $error("frame_out data changed while req was high");

    down_ack_after_req: assert property (@(posedge clk) disable iff (!reset)
        $rose(down_ack) |-> down_req)
        else $error("frame_out ack rose without req");

endmodule

bind frame_buffer clock_props i_clock_props (
    .clk         (clk),
    .reset       (reset),
    .up_req      (upstream.req),
    .up_ack      (upstream.ack),
    .up_digits   (upstream.digits),
    .up_blink    (upstream.blink),
    .down_req    (downstream.req),
    .down_ack    (downstream.ack),
    .down_digits (downstream.digits),
    .down_blink  (downstream.blink)
);

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock import clock_pkg::*; ();

    localparam int CENTI_DIV    = 20;
    localparam int SCAN_DIV     = 4;
    localparam int BLINK_DIV    = 64;
    localparam int ITERS        = 6;
    localparam int SCAN_LEN     = NUM_DIGITS * SCAN_DIV;
    localparam int WATCH_LEN    = 4 * BLINK_DIV;  // two blink periods
    localparam int SETTLE_SCANS = 8;
    localparam int MAX_CYCLES   = (64 + ITERS * 256 + ITERS + 2) * CENTI_DIV
                                + (2 * ITERS + 3) * (SETTLE_SCANS * SCAN_LEN + WATCH_LEN + 4)
                                + 1000;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  time_format;
    logic [1:0]            para_select;
    logic                  read_para;
    logic [DIGIT_W-1:0]    data_h;
    logic [DIGIT_W-1:0]    data_l;
    logic                  afternoon;
    logic [7:0]            segs;
    logic [NUM_DIGITS-1:0] an;

    logic [31:0]           lfsr_state;
    int                    mismatches  = 0;
    int                    failures    = 0;
    int                    cycle_count = 0;
    int                    mon_pos;
    bit                    frame_seen  = 1'b0;
    int                    m_hours;
    int                    m_min;
    int                    m_sec;
    int                    m_centi;
    bit                    m_fmt;
    logic [NUM_DIGITS-1:0] exp_blink;
    int                    exp_code [NUM_DIGITS];

    clock_top #(
        .CENTI_DIV (CENTI_DIV),
        .SCAN_DIV  (SCAN_DIV),
        .BLINK_DIV (BLINK_DIV)
    ) i_clock_top (
        .clk         (clk),
        .reset       (reset),
        .time_format (time_format),
        .para_select (para_select),
        .read_para   (read_para),
        .data_h      (data_h),
        .data_l      (data_l),
        .afternoon   (afternoon),
        .segs        (segs),
        .an          (an)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // random source and display decoding
    ////////////////////////////////////////////////////////////
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int width, output int value);
        value = 0;
        repeat (width) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // active low gfedcba, 15 for dark
    function automatic int seg_code(input logic [6:0] s);
        case (s)
            7'b100_0000: return 0;
            7'b111_1001: return 1;
            7'b010_0100: return 2;
            7'b011_0000: return 3;
            7'b001_1001: return 4;
            7'b001_0010: return 5;
            7'b000_0010: return 6;
            7'b111_1000: return 7;
            7'b000_0000: return 8;
            7'b001_0000: return 9;
            7'b111_1111: return 15;
            default:     return -1;
        endcase
    endfunction

    function automatic int an_pos(input logic [NUM_DIGITS-1:0] a);
        int p;
        int i;
        p = -1;
        if ($countones(~a) == 1) begin
            for (i = 0; i < NUM_DIGITS; i++) begin
                if (!a[i]) p = i;
            end
        end
        return p;
    endfunction

    ////////////////////////////////////////////////////////////
    // time model
    ////////////////////////////////////////////////////////////
    function automatic int set_value(input int dh, input int dl, input int modulus);
        int h;
        int l;
        h = (dh > int'(BCD_MAX)) ? int'(BCD_MAX) : dh;
        l = (dl > int'(BCD_MAX)) ? int'(BCD_MAX) : dl;
        return (10 * h + l) % modulus;
    endfunction

    task automatic advance_ticks(input int n);
        repeat (n) begin
            m_centi++;
            if (m_centi == CENTI_PER_SEC) begin
                m_centi = 0;
                m_sec++;
                if (m_sec == SEC_PER_MIN) begin
                    m_sec = 0;
                    m_min++;
                    if (m_min == MIN_PER_HOUR) begin
                        m_min   = 0;
                        m_hours = (m_hours + 1) % HOURS_PER_DAY;
                    end
                end
            end
        end
    endtask

    // stay mid-interval so the tick count is exact
    task automatic run_free(input int n);
        repeat (n * CENTI_DIV + CENTI_DIV / 2) @(negedge clk);
        advance_ticks(n);
    endtask

    task automatic enter_setting(input logic [1:0] field, input int dh, input int dl,
                                 input bit fmt);
        @(negedge clk);
        para_select = field;
        data_h      = DIGIT_W'(dh);
        data_l      = DIGIT_W'(dl);
        time_format = fmt;
        m_fmt       = fmt;
        case (field)
            PARA_SEC: begin
                m_sec     = set_value(dh, dl, SEC_PER_MIN);
                exp_blink = 8'b0000_1100;
            end
            PARA_MIN: begin
                m_min     = set_value(dh, dl, MIN_PER_HOUR);
                exp_blink = 8'b0011_0000;
            end
            default: begin
                m_hours   = set_value(dh, dl, HOURS_PER_DAY);
                exp_blink = 8'b1100_0000;
            end
        endcase
    endtask

    task automatic commit_and_run(input int n);
        @(negedge clk);
        read_para = 1'b1;
        @(negedge clk);
        read_para   = 1'b0;
        para_select = PARA_NONE;  // re-arm setting
        exp_blink   = '0;
        run_free(n);
    endtask

    ////////////////////////////////////////////////////////////
    // display checks
    ////////////////////////////////////////////////////////////
    task automatic watch(input int len, input bit report, output int bad);
        int                    p;
        int                    code;
        int                    i;
        logic [NUM_DIGITS-1:0] dark_seen;
        logic [NUM_DIGITS-1:0] lit_seen;
        bad       = 0;
        dark_seen = '0;
        lit_seen  = '0;
        repeat (len) begin
            @(negedge clk);
            p    = an_pos(an);
            code = seg_code(segs[6:0]);
            if (p < 0) begin
                bad++;                            // monitor reports it
            end else if (exp_blink[p] && code == 15) begin
                dark_seen[p] = 1'b1;
            end else if (code == exp_code[p]) begin
                lit_seen[p] = 1'b1;
            end else begin
                bad++;
                if (report) begin
                    mismatches++;
                    $display("mismatch at %0t: position %0d shows %0d, expected %0d",
                             $time, p, code, exp_code[p]);
                end
            end
        end
        if (report) begin
            for (i = 0; i < NUM_DIGITS; i++) begin
                if (exp_blink[i] && !(dark_seen[i] && lit_seen[i])) begin
                    failures++;
                    $display("error at %0t: position %0d did not blink", $time, i);
                end
            end
        end
    endtask

    task automatic check_display();
        int scans;
        int bad;
        int hd;
        hd = (m_fmt && m_hours > HALF_DAY) ? m_hours - HALF_DAY : m_hours;
        exp_code[7] = hd / 10;
        exp_code[6] = hd % 10;
        exp_code[5] = m_min / 10;
        exp_code[4] = m_min % 10;
        exp_code[3] = m_sec / 10;
        exp_code[2] = m_sec % 10;
        exp_code[1] = m_centi / 10;
        exp_code[0] = m_centi % 10;
        scans = 0;
        bad   = 1;
        while (bad != 0 && scans < SETTLE_SCANS) begin
            watch(SCAN_LEN, 1'b0, bad);
            scans++;
        end
        if (bad != 0) begin
            failures++;
            $display("error at %0t: display did not settle within %0d scans",
                     $time, SETTLE_SCANS);
        end
        watch(WATCH_LEN, 1'b1, bad);
        if (afternoon !== (m_fmt && m_hours > HALF_DAY)) begin
            mismatches++;
            $display("mismatch at %0t: afternoon is %b for hour %0d, format %0d",
                     $time, afternoon, m_hours, m_fmt);
        end
    endtask

    // dark until the first frame, then one digit at a time
    always @(negedge clk) begin
        if (!frame_seen) begin
            if (an != '1) begin
                if (!reset) begin
                    failures++;
                    $display("error at %0t: digit enabled during reset", $time);
                end
                frame_seen = 1'b1;
            end else if (segs != SEG_DARK) begin
                mismatches++;
                $display("mismatch at %0t: segments %b lit before first frame", $time, segs);
            end
        end
        if (frame_seen) begin
            mon_pos = an_pos(an);
            if (mon_pos < 0) begin
                failures++;
                $display("error at %0t: an %b does not select exactly one digit", $time, an);
            end else if (segs[7] != !POINT_POSITIONS[mon_pos]) begin
                mismatches++;
                $display("mismatch at %0t: wrong decimal point at position %0d",
                         $time, mon_pos);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int n;
        int r;
        int dh;
        int dl;
        int hv;
        int iter;
        reset       = 1'b0;
        time_format = 1'b0;
        para_select = PARA_NONE;
        read_para   = 1'b0;
        data_h      = '0;
        data_l      = '0;
        lfsr_state  = 32'h1680_af13;
        m_hours     = 0;
        m_min       = 0;
        m_sec       = 0;
        m_centi     = 0;
        m_fmt       = 1'b0;
        exp_blink   = '0;
        repeat (3) @(negedge clk);
        reset = 1'b1;

        // free run from midnight, then freeze on seconds
        rand_bits(6, n);
        run_free(n + 1);
        rand_bits(4, dh);
        rand_bits(4, dl);
        enter_setting(PARA_SEC, dh, dl, 1'b0);
        check_display();

        for (iter = 0; iter < ITERS; iter++) begin
            rand_bits(4, r);
            rand_bits(4, dh);
            rand_bits(4, dl);
            rand_bits(1, n);
            enter_setting(2'(1 + r % 3), dh, dl, n[0]);
            check_display();
            rand_bits(8, n);
            commit_and_run(n + 1);
            rand_bits(4, dh);
            rand_bits(4, dl);
            enter_setting(PARA_SEC, dh, dl, m_fmt);
            check_display();
        end

        // afternoon hours in both formats
        rand_bits(4, r);
        hv = 13 + r % 11;
        enter_setting(PARA_HOUR, hv / 10, hv % 10, 1'b1);
        check_display();
        enter_setting(PARA_HOUR, hv / 10, hv % 10, 1'b0);
        check_display();

        $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* src.f */
common/clock_pkg.sv
common/frame_if.sv
src/timekeeping/digit_formatter.sv
src/timekeeping/time_keeper.sv
src/frame_buffer.sv
src/display/seg_scanner.sv
src/clock_top.sv
bench/clock_props.sv
bench/tb_clock.sv

/* Makefile */
TOOL      = verilator
TOP       = tb_clock
RTL_TOP   = clock_top
FILELIST  = src.f
FLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINTFLAGS = --lint-only -Wall --timing --top-module $(TOP)
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above
PASS_MSG  = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; fi

lint:
	$(TOOL) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
